// File: Makefile
VERILATOR	= verilator
VFLAGS		= --binary --assert --timing -j 0
TOP			= per_sys_tb
FLIST		= per_sys.f

SRCS	= $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS	= $(wildcard hdl/*.svh)
BIN		= obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: hdl/per_ctrl_regs.sv
`timescale 1ns/1ps
`include "per_sys_defines.svh"

module per_ctrl_regs (
	input											clock_i,
	input											rst_n_i,

	// queue read side
	input											empty_i,
	input	per_sys_pkg::per_req_t					req_i,		// queue head
	output	logic									pop_o,

	// status inputs
	input	[`PER_DATA_W-1:0]						comm_cache0_i,
	input	[`PER_DATA_W-1:0]						comm_cache1_i,
	input	[`PER_NUM_CYC*`PER_DATA_W-1:0]			cycle_counts_i,

	// control outputs
	output	logic	[`PER_DATA_W-1:0]				comm_o,
	output	logic	[`PER_DATA_W-1:0]				phase_o,
	output	logic	[`PER_METRIC_W-1:0]				metric_sel_o,
	output	logic	[`PER_SEED_W-1:0]				shift_sample_rate_o,
	output	logic									reset_system_o,

	// read responses
	output	logic	[`PER_DATA_W-1:0]				data_core_o,
	output	logic									rvalid_core_o,
	output	logic	[`PER_DATA_W-1:0]				data_cs_o,
	output	logic									rvalid_cs_o
);

logic						wr_en, rd_core, rd_cs;
logic	[`PER_DATA_W-1:0]	rd_data;
logic	[`PER_ADDR_W-1:0]	cyc_off;		// word index into cycle_counts_i

assign pop_o	= ~empty_i;						// drain one request per cycle
assign wr_en	= pop_o & req_i.rw;
assign rd_core	= pop_o & ~req_i.rw & (req_i.src == per_sys_pkg::SRC_CORE);
assign rd_cs	= pop_o & ~req_i.rw & (req_i.src == per_sys_pkg::SRC_CS);
assign cyc_off	= req_i.addr - `PER_ADDR_W'(`REG_CYC0);

// read mux
// ---------------------------------------------------------------------------
always_comb begin
	rd_data = '0;		// unmapped reads give zero
	case (req_i.addr)
		`REG_COMM:		rd_data = comm_o;
		`REG_PHASE:		rd_data = phase_o;
		`REG_METRIC:	rd_data[`PER_METRIC_W-1:0] = metric_sel_o;
		`REG_SEED:		rd_data[`PER_SEED_W-1:0] = shift_sample_rate_o;
		`REG_SYSRST:	rd_data[0] = reset_system_o;
		`REG_CACHE0:	rd_data = comm_cache0_i;
		`REG_CACHE1:	rd_data = comm_cache1_i;
		default: begin
			// counter words 7..12
			if (req_i.addr >= `REG_CYC0 && req_i.addr < `REG_CYC0 + `PER_NUM_CYC)
				rd_data = cycle_counts_i[cyc_off*`PER_DATA_W +: `PER_DATA_W];
		end
	endcase
end

// control registers, write lands at the pop edge
// ---------------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		comm_o				<= '0;
		phase_o				<= '0;
		metric_sel_o		<= '0;
		shift_sample_rate_o	<= '0;
		reset_system_o		<= 1'b1;	// core held until a master lets go
	end else if (wr_en) begin
		case (req_i.addr)
			`REG_COMM:		comm_o <= req_i.data;
			`REG_PHASE:		phase_o <= req_i.data;
			`REG_METRIC:	metric_sel_o <= req_i.data[`PER_METRIC_W-1:0];
			`REG_SEED:		shift_sample_rate_o <= req_i.data[`PER_SEED_W-1:0];
			`REG_SYSRST:	reset_system_o <= req_i.data[0];
			default:		;		// ro or unmapped, dropped
		endcase
	end
end

// response strobes
always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		rvalid_core_o	<= 1'b0;
		rvalid_cs_o		<= 1'b0;
	end else begin
		rvalid_core_o	<= rd_core;
		rvalid_cs_o		<= rd_cs;
	end
end

// response data, held between strobes
always_ff @(posedge clock_i) begin
	if (rd_core)
		data_core_o <= rd_data;
	if (rd_cs)
		data_cs_o <= rd_data;
end

endmodule

// File: hdl/per_req_arbiter.sv
`timescale 1ns/1ps
`include "per_sys_defines.svh"

module per_req_arbiter (
	input							clock_i,
	input							rst_n_i,

	// core side
	input							req_core_i,		// one-cycle strobe
	input							rw_core_i,
	input	[`PER_ADDR_W-1:0]		add_core_i,
	input	[`PER_DATA_W-1:0]		data_core_i,

	// cs side
	input							req_cs_i,		// one-cycle strobe
	input							rw_cs_i,
	input	[`PER_ADDR_W-1:0]		add_cs_i,
	input	[`PER_DATA_W-1:0]		data_cs_i,

	// queue write port
	output	logic					push_o,
	output	per_sys_pkg::per_req_t	req_o
);

// pending slots
// ---------------------------------------------------------------------------
logic					pend_core_q, pend_cs_q;	// slot holds a request
per_sys_pkg::per_req_t	rec_core_q, rec_cs_q;	// captured records
logic					old_cs_q;				// cs waited through a lost cycle
logic					grant_core, grant_cs;

// older slot wins, core on a tie
assign grant_core	= pend_core_q & (~pend_cs_q | ~old_cs_q);
assign grant_cs		= pend_cs_q & ~grant_core;

assign push_o	= pend_core_q | pend_cs_q;			// one record per cycle at most
assign req_o	= grant_core ? rec_core_q : rec_cs_q;

// slot valid bits and age
always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		pend_core_q	<= 1'b0;
		pend_cs_q	<= 1'b0;
		old_cs_q	<= 1'b0;
	end else begin
		// a new strobe refills a slot even in its grant cycle
		if (req_core_i)
			pend_core_q <= 1'b1;
		else if (grant_core)
			pend_core_q <= 1'b0;

		if (req_cs_i)
			pend_cs_q <= 1'b1;
		else if (grant_cs)
			pend_cs_q <= 1'b0;

		old_cs_q <= pend_cs_q & ~grant_cs;	// cs lost this round, goes first next
	end
end

// record capture, source stamped here so the consumer never decodes it
always_ff @(posedge clock_i) begin
	if (req_core_i) begin
		rec_core_q.src	<= per_sys_pkg::SRC_CORE;
		rec_core_q.rw	<= rw_core_i;
		rec_core_q.addr	<= add_core_i;
		rec_core_q.data	<= data_core_i;
	end
	if (req_cs_i) begin
		rec_cs_q.src	<= per_sys_pkg::SRC_CS;
		rec_cs_q.rw		<= rw_cs_i;
		rec_cs_q.addr	<= add_cs_i;
		rec_cs_q.data	<= data_cs_i;
	end
end

endmodule

// File: hdl/per_req_fifo.sv
`timescale 1ns/1ps
`include "per_sys_defines.svh"

module per_req_fifo #(
	parameter type	T		= per_sys_pkg::per_req_t,	// queued record
	parameter int	DEPTH	= `PER_FIFO_DEPTH
) (
	input			clock_i,
	input			rst_n_i,

	input			push_i,		// dropped when full
	input	T		data_i,
	input			pop_i,		// dropped when empty
	output	T		data_o,		// head, combinational
	output	logic	empty_o,
	output	logic	full_o
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

T					mem_q [DEPTH];		// storage
logic	[AW-1:0]	wr_ptr_q, rd_ptr_q;
logic	[CW-1:0]	count_q;			// occupancy
logic				do_push, do_pop;

assign do_push	= push_i & ~full_o;
assign do_pop	= pop_i & ~empty_o;

assign empty_o	= (count_q == '0);
assign full_o	= (count_q == CW'(DEPTH));
assign data_o	= mem_q[rd_ptr_q];

// pointers and count
// ---------------------------------------------------------------------------
always_ff @(posedge clock_i) begin
	if (!rst_n_i) begin
		wr_ptr_q	<= '0;
		rd_ptr_q	<= '0;
		count_q		<= '0;
	end else begin
		if (do_push)
			wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;	// wrap
		if (do_pop)
			rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
		// both at once leaves the count alone
		if (do_push && !do_pop)
			count_q <= count_q + 1'b1;
		else if (do_pop && !do_push)
			count_q <= count_q - 1'b1;
	end
end

always_ff @(posedge clock_i) begin
	if (do_push)
		mem_q[wr_ptr_q] <= data_i;
end

endmodule

// File: hdl/per_sys.sv
`timescale 1ns/1ps
`include "per_sys_defines.svh"

module per_sys (
	// system ports
	input											clock_i,
	input											rst_n_i,

	// core side
	input											req_core_i,
	input											rw_core_i,
	input	[`PER_ADDR_W-1:0]						add_core_i,
	input	[`PER_DATA_W-1:0]						data_core_i,
	output	[`PER_DATA_W-1:0]						data_core_o,
	output											rvalid_core_o,

	// cs side
	input											req_cs_i,
	input											rw_cs_i,
	input	[`PER_ADDR_W-1:0]						add_cs_i,
	input	[`PER_DATA_W-1:0]						data_cs_i,
	output	[`PER_DATA_W-1:0]						data_cs_o,
	output											rvalid_cs_o,

	// cache and counter status
	input	[`PER_DATA_W-1:0]						comm_cache0_i,
	input	[`PER_DATA_W-1:0]						comm_cache1_i,
	input	[`PER_NUM_CYC*`PER_DATA_W-1:0]			cycle_counts_i,

	// control of the core
	output	[`PER_DATA_W-1:0]						comm_o,
	output	[`PER_DATA_W-1:0]						phase_o,
	output	[`PER_METRIC_W-1:0]						metric_sel_o,
	output	[`PER_SEED_W-1:0]						shift_sample_rate_o,
	output											reset_system_o
);

// arbiter -> queue -> register unit
// ---------------------------------------------------------------------------
logic					arb_push;
per_sys_pkg::per_req_t	arb_req;		// record into the queue
per_sys_pkg::per_req_t	fifo_head;		// record at the head
logic					fifo_empty, fifo_full, regs_pop;	// full is watched by the checker

per_req_arbiter u_arbiter (
	.clock_i		(clock_i		),
	.rst_n_i		(rst_n_i		),
	.req_core_i		(req_core_i		),
	.rw_core_i		(rw_core_i		),
	.add_core_i		(add_core_i		),
	.data_core_i	(data_core_i	),
	.req_cs_i		(req_cs_i		),
	.rw_cs_i		(rw_cs_i		),
	.add_cs_i		(add_cs_i		),
	.data_cs_i		(data_cs_i		),
	.push_o			(arb_push		),
	.req_o			(arb_req		)
);

per_req_fifo #(
	.T				(per_sys_pkg::per_req_t	),
	.DEPTH			(`PER_FIFO_DEPTH		)
) u_fifo (
	.clock_i		(clock_i		),
	.rst_n_i		(rst_n_i		),
	.push_i			(arb_push		),
	.data_i			(arb_req		),
	.pop_i			(regs_pop		),
	.data_o			(fifo_head		),
	.empty_o		(fifo_empty		),
	.full_o			(fifo_full		)
);

per_ctrl_regs u_regs (
	.clock_i				(clock_i				),
	.rst_n_i				(rst_n_i				),
	.empty_i				(fifo_empty				),
	.req_i					(fifo_head				),
	.pop_o					(regs_pop				),
	.comm_cache0_i			(comm_cache0_i			),
	.comm_cache1_i			(comm_cache1_i			),
	.cycle_counts_i			(cycle_counts_i			),
	.comm_o					(comm_o					),
	.phase_o				(phase_o				),
	.metric_sel_o			(metric_sel_o			),
	.shift_sample_rate_o	(shift_sample_rate_o	),
	.reset_system_o			(reset_system_o			),
	.data_core_o			(data_core_o			),
	.rvalid_core_o			(rvalid_core_o			),
	.data_cs_o				(data_cs_o				),
	.rvalid_cs_o			(rvalid_cs_o			)
);

endmodule

// File: hdl/per_sys_defines.svh
`ifndef PER_SYS_DEFINES_SVH
`define PER_SYS_DEFINES_SVH

// bus widths
// ---------------------------------------------------------------------------
`define PER_ADDR_W		4		// word address into the register bank
`define PER_DATA_W		32		// one bus word
`define PER_FIFO_DEPTH	4		// request queue entries

// field widths of the narrow control registers
`define PER_METRIC_W	2		// metric selector
`define PER_SEED_W		19		// sample-rate seed
`define PER_NUM_CYC		6		// cycle counter words from the core

// register map
// ---------------------------------------------------------------------------
`define REG_COMM		0		// command word to the core
`define REG_PHASE		1		// clock phase word
`define REG_METRIC		2		// metric selector
`define REG_SEED		3		// sample-rate seed
`define REG_SYSRST		4		// core system reset, bit 0
`define REG_CACHE0		5		// cache 0 status, ro
`define REG_CACHE1		6		// cache 1 status, ro
`define REG_CYC0		7		// first cycle count word, 7..12 ro

`endif

// File: hdl/per_sys_pkg.sv
`include "per_sys_defines.svh"

package per_sys_pkg;

	// which master a request came from
	typedef enum logic {
		SRC_CORE	= 1'b0,		// processor core
		SRC_CS		= 1'b1		// external comm system
	} per_src_e;

	// ---------------------------------------------------------------------------
	// one queued request, 38 bits
	// ---------------------------------------------------------------------------
	typedef struct packed {
		per_src_e					src;	// origin, selects the response port
		logic						rw;		// 1 = write
		logic [`PER_ADDR_W-1:0]		addr;	// word address
		logic [`PER_DATA_W-1:0]		data;	// write data, don't care on reads
	} per_req_t;

	// record width is also 1+1+addr+data, used for sizing checks
	localparam int PER_REQ_W = $bits(per_req_t);

endpackage

// File: per_sys.f
+incdir+hdl
hdl/per_sys_pkg.sv
hdl/per_req_arbiter.sv
hdl/per_req_fifo.sv
hdl/per_ctrl_regs.sv
hdl/per_sys.sv
tb/per_sys_props.sv
tb/per_sys_tb.sv

// File: tb/per_sys_props.sv
`timescale 1ns/1ps

module per_sys_props (
	input	clock_i,
	input	rst_n_i,
	input	push_i,			// queue write strobe
	input	full_i,			// queue full flag
	input	rvalid_core_i,
	input	rvalid_cs_i
);

// a push into a full queue would be dropped
a_no_push_full: assert property (@(posedge clock_i) disable iff (!rst_n_i)
	!(push_i && full_i))
	else $error("request pushed while the queue is full");

// response strobes come out of a reset edge low
a_rvalid_reset: assert property (@(posedge clock_i)
	!rst_n_i |=> (!rvalid_core_i && !rvalid_cs_i))
	else $error("read response strobe high during reset");

// one-cycle strobes only
a_core_single: assert property (@(posedge clock_i) disable iff (!rst_n_i)
	rvalid_core_i |=> !rvalid_core_i)
	else $error("core rvalid high for two cycles in a row");

a_cs_single: assert property (@(posedge clock_i) disable iff (!rst_n_i)
	rvalid_cs_i |=> !rvalid_cs_i)
	else $error("cs rvalid high for two cycles in a row");

endmodule

// push and full are the queue's own ports, seen at the top level nets
bind per_sys per_sys_props u_props (
	.clock_i		(clock_i		),
	.rst_n_i		(rst_n_i		),
	.push_i			(arb_push		),
	.full_i			(fifo_full		),
	.rvalid_core_i	(rvalid_core_o	),
	.rvalid_cs_i	(rvalid_cs_o	)
);

// File: tb/per_sys_tb.sv
`timescale 1ns/1ps
`include "per_sys_defines.svh"

module per_sys_tb;

localparam int MAX_CYCLES	= 2000;		// whole run is near 130 cycles
localparam int RD_WAIT		= 8;		// rvalid bound per read

logic							clock, rst_n;
logic							req_core, rw_core, req_cs, rw_cs;
logic	[`PER_ADDR_W-1:0]		add_core, add_cs;
logic	[`PER_DATA_W-1:0]		wdata_core, wdata_cs;
logic	[`PER_DATA_W-1:0]		data_core, data_cs;		// read data back
logic							rvalid_core, rvalid_cs;
logic	[`PER_DATA_W-1:0]		cache0, cache1;
logic	[6*`PER_DATA_W-1:0]		cyc_counts;
logic	[`PER_DATA_W-1:0]		comm, phase;
logic	[`PER_METRIC_W-1:0]		metric;
logic	[`PER_SEED_W-1:0]		sample_seed;
logic							sysrst;

int		errors = 0, checks = 0;
int		cycles = 0;
int		n_rv_core = 0, n_rv_cs = 0;		// strobes seen since reset
int		rnd_seed = 77;
// register model, in read-back form
logic	[31:0]	exp_comm, exp_phase, exp_metric, exp_seed, exp_sysrst;

per_sys u_per_sys (
	.clock_i(clock), .rst_n_i(rst_n),
	.req_core_i(req_core), .rw_core_i(rw_core), .add_core_i(add_core),
	.data_core_i(wdata_core), .data_core_o(data_core), .rvalid_core_o(rvalid_core),
	.req_cs_i(req_cs), .rw_cs_i(rw_cs), .add_cs_i(add_cs),
	.data_cs_i(wdata_cs), .data_cs_o(data_cs), .rvalid_cs_o(rvalid_cs),
	.comm_cache0_i(cache0), .comm_cache1_i(cache1), .cycle_counts_i(cyc_counts),
	.comm_o(comm), .phase_o(phase), .metric_sel_o(metric),
	.shift_sample_rate_o(sample_seed), .reset_system_o(sysrst)
);

initial begin
	clock = 1'b0;
	forever #50 clock = ~clock;		// 100 ns period
end

// cycle count, strobe count, timeout
always @(posedge clock) begin
	cycles <= cycles + 1;
	if (rst_n && rvalid_core === 1'b1)
		n_rv_core <= n_rv_core + 1;
	if (rst_n && rvalid_cs === 1'b1)
		n_rv_cs <= n_rv_cs + 1;
	if (cycles >= MAX_CYCLES) begin
		$display("timeout, run stopped after %0d cycles with %0d errors", cycles, errors);
		$display("sim failed");
		$finish;
	end
end

// ---------------------------------------------------------------------------
// helpers
// ---------------------------------------------------------------------------
task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
	checks++;
	if (exp_v !== act_v) begin
		errors++;
		$display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
	end
endtask

// one-cycle request strobe from either master
task automatic strobe(input bit to_cs, input bit wr, input logic [`PER_ADDR_W-1:0] addr,
		input logic [`PER_DATA_W-1:0] d);
	if (to_cs) begin
		req_cs = 1'b1;
		rw_cs = wr;
		add_cs = addr;
		wdata_cs = d;
	end else begin
		req_core = 1'b1;
		rw_core = wr;
		add_core = addr;
		wdata_core = d;
	end
	@(posedge clock);
	#1;
	req_core = 1'b0;
	req_cs = 1'b0;
endtask

// wait for this master's rvalid and compare its data
task automatic read_back(input bit from_cs, input string name, input logic [31:0] exp_v);
	bit got;
	got = 1'b0;
	for (int i = 0; i < RD_WAIT && !got; i++) begin
		@(posedge clock);
		#1;
		if (from_cs ? rvalid_cs : rvalid_core) begin
			got = 1'b1;
			check(name, exp_v, from_cs ? data_cs : data_core);
		end
	end
	if (!got) begin
		errors++;
		$display("%s: no read response within %0d cycles", name, RD_WAIT);
	end
endtask

task automatic core_write(input logic [`PER_ADDR_W-1:0] addr, input logic [31:0] d);
	strobe(1'b0, 1'b1, addr, d);
	@(posedge clock);		// idle cycle, rate rule
	#1;
endtask

task automatic cs_write(input logic [`PER_ADDR_W-1:0] addr, input logic [31:0] d);
	strobe(1'b1, 1'b1, addr, d);
	@(posedge clock);
	#1;
endtask

task automatic core_read(input string name, input logic [`PER_ADDR_W-1:0] addr,
		input logic [31:0] exp_v);
	strobe(1'b0, 1'b0, addr, '0);
	read_back(1'b0, name, exp_v);
endtask

task automatic cs_read(input string name, input logic [`PER_ADDR_W-1:0] addr,
		input logic [31:0] exp_v);
	strobe(1'b1, 1'b0, addr, '0);
	read_back(1'b1, name, exp_v);
endtask

// ---------------------------------------------------------------------------
// directed tests
// ---------------------------------------------------------------------------
task automatic test_reset_state();
	check("reset comm", 0, comm);
	check("reset phase", 0, phase);
	check("reset metric", 0, 32'(metric));
	check("reset seed", 0, 32'(sample_seed));
	check("reset sysrst", 1, 32'(sysrst));			// core held
	check("reset rvalid count", 0, n_rv_core + n_rv_cs);
endtask

task automatic test_core_regs();
	exp_comm = $random(rnd_seed);
	core_write(`REG_COMM, exp_comm);
	exp_phase = $random(rnd_seed);
	core_write(`REG_PHASE, exp_phase);
	exp_metric = $random(rnd_seed);
	core_write(`REG_METRIC, exp_metric);
	exp_metric = exp_metric & 32'h3;				// 2-bit field
	exp_seed = $random(rnd_seed);
	core_write(`REG_SEED, exp_seed);
	exp_seed = exp_seed & 32'h7_ffff;				// 19-bit field
	core_read("core comm", `REG_COMM, exp_comm);
	core_read("core phase", `REG_PHASE, exp_phase);
	core_read("core metric", `REG_METRIC, exp_metric);
	core_read("core seed", `REG_SEED, exp_seed);
	// reads came after the writes, so outputs are settled
	check("comm out", exp_comm, comm);
	check("phase out", exp_phase, phase);
	check("metric out", exp_metric, 32'(metric));
	check("seed out", exp_seed, 32'(sample_seed));
endtask

task automatic test_sharing();
	exp_phase = $random(rnd_seed);
	cs_write(`REG_PHASE, exp_phase);
	core_read("shared phase", `REG_PHASE, exp_phase);
	check("shared phase out", exp_phase, phase);
	cache0 = $random(rnd_seed);
	cache1 = $random(rnd_seed);
	for (int k = 0; k < 6; k++)
		cyc_counts[32*k +: 32] = $random(rnd_seed);
	core_read("cache0 status", `REG_CACHE0, cache0);
	cs_read("cache1 status", `REG_CACHE1, cache1);
	for (int k = 0; k < 6; k++) begin
		if (k % 2 == 1)
			cs_read("cycle word", 4'(`REG_CYC0 + k), cyc_counts[32*k +: 32]);
		else
			core_read("cycle word", 4'(`REG_CYC0 + k), cyc_counts[32*k +: 32]);
	end
endtask

// both masters every two cycles, responses collected with their cycle
task automatic test_dual_reads();
	int				core_cyc[$], cs_cyc[$];
	logic [31:0]	core_dat[$], cs_dat[$];
	fork
		begin
			for (int k = 0; k < 8; k++) begin
				req_core = 1'b1;
				rw_core = 1'b0;
				add_core = 4'(`REG_CYC0 + k % 6);
				req_cs = 1'b1;
				rw_cs = 1'b0;
				add_cs = `REG_COMM;
				@(posedge clock);
				#1;
				req_core = 1'b0;
				req_cs = 1'b0;
				@(posedge clock);
				#1;
			end
		end
		begin
			for (int i = 0; i < 32; i++) begin		// 16 issue cycles plus margin
				@(posedge clock);
				#1;
				if (rvalid_core) begin
					core_cyc.push_back(cycles);
					core_dat.push_back(data_core);
				end
				if (rvalid_cs) begin
					cs_cyc.push_back(cycles);
					cs_dat.push_back(data_cs);
				end
			end
		end
	join
	check("dual core strobes", 8, core_cyc.size());
	check("dual cs strobes", 8, cs_cyc.size());
	for (int k = 0; k < core_cyc.size() && k < cs_cyc.size(); k++) begin
		check("dual core data", cyc_counts[32*(k%6) +: 32], core_dat[k]);
		check("dual cs data", exp_comm, cs_dat[k]);
		if (core_cyc[k] > cs_cyc[k]) begin
			errors++;
			$display("dual reads: core response %0d came after the cs response", k);
		end
	end
endtask

task automatic test_ignored();
	cs_write(`REG_CACHE0, $random(rnd_seed));
	core_write(`REG_CACHE1, $random(rnd_seed));
	core_write(`REG_CYC0, $random(rnd_seed));
	cs_write(4'd13, $random(rnd_seed));				// unmapped
	core_write(4'd15, $random(rnd_seed));
	core_read("ro cache0", `REG_CACHE0, cache0);
	cs_read("ro cache1", `REG_CACHE1, cache1);
	core_read("ro cycle word", `REG_CYC0, cyc_counts[31:0]);
	core_read("unmapped 13", 4'd13, 0);
	cs_read("unmapped 14", 4'd14, 0);
	core_read("unmapped 15", 4'd15, 0);
	cs_read("comm kept", `REG_COMM, exp_comm);
	check("comm out kept", exp_comm, comm);
	check("phase out kept", exp_phase, phase);
	check("metric out kept", exp_metric, 32'(metric));
	check("seed out kept", exp_seed, 32'(sample_seed));
	check("sysrst out kept", exp_sysrst, 32'(sysrst));
endtask

task automatic test_reset_release();
	cs_write(`REG_SYSRST, 0);
	cs_read("sysrst cleared", `REG_SYSRST, 0);
	check("sysrst out low", 0, 32'(sysrst));
	core_write(`REG_SYSRST, 1);
	core_read("sysrst set", `REG_SYSRST, 1);
	check("sysrst out high", 1, 32'(sysrst));
endtask

initial begin
	rst_n = 1'b0;
	req_core = 1'b0;
	rw_core = 1'b0;
	add_core = '0;
	wdata_core = '0;
	req_cs = 1'b0;
	rw_cs = 1'b0;
	add_cs = '0;
	wdata_cs = '0;
	cache0 = '0;
	cache1 = '0;
	cyc_counts = '0;
	exp_comm = '0;
	exp_phase = '0;
	exp_metric = '0;
	exp_seed = '0;
	exp_sysrst = 32'd1;
	repeat (4) @(posedge clock);		// reset for 4 cycles
	#1;
	rst_n = 1'b1;
	@(posedge clock);
	#1;
	check("request record width", 38, per_sys_pkg::PER_REQ_W);	// src, rw, addr, data
	test_reset_state();
	test_core_regs();
	test_sharing();
	test_dual_reads();
	test_ignored();
	test_reset_release();
	$display("%0d checks, %0d errors", checks, errors);
	if (errors == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule
